//--- project.f
common/tcam_pkg.sv
common/tcam_write_if.sv
common/tcam_search_if.sv
verilog/priority_pick.sv
tcam/tcam_store.sv
tcam/tcam_search.sv
verilog/tcam_top.sv
verif/tcam_sva.sv
verif/tcam_checker.sv
verif/tcam_tb.sv

//--- Makefile
# Verilator build and run for the TCAM testbench
# any variable can be overridden, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tcam_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# output is shown and then searched for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/tcam_tb.sv
`timescale 1ns/1ps

module tcam_tb;

  localparam int                    DATA_W  = tcam_pkg::DEF_DATA_W;
  localparam int                    DEPTH   = tcam_pkg::DEF_DEPTH;
  localparam int                    N_WRITE = tcam_pkg::DEF_N_WRITE;
  localparam int                    N_READ  = tcam_pkg::DEF_N_READ;
  localparam tcam_pkg::sel_policy_e POLICY  = tcam_pkg::DEF_POLICY;
  localparam int                    ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // random phase length, and a rough cycle budget for the directed tests
  localparam int RAND_CYCLES     = 400;
  localparam int DIRECTED_CYCLES = 80;
  localparam int TIMEOUT_NS      = (8 + DIRECTED_CYCLES + RAND_CYCLES) * 10 + 500;

  logic                           clk;
  logic                           arst_n;
  logic [N_WRITE-1:0]             wr_en;
  logic [N_WRITE-1:0][DATA_W-1:0] wr_mask;
  logic [N_WRITE-1:0][DATA_W-1:0] wr_data;
  logic [N_WRITE-1:0][ADDR_W-1:0] wr_addr;
  logic [N_READ-1:0]              srch_en;
  logic [N_READ-1:0][DATA_W-1:0]  srch_mask;
  logic [N_READ-1:0][DATA_W-1:0]  srch_key;
  logic [N_READ-1:0]              res_valid;
  logic [N_READ-1:0]              res_match;
  logic [N_READ-1:0]              res_multi;
  logic [N_READ-1:0][ADDR_W-1:0]  res_addr;

  // test bookkeeping towards the checker
  logic        test_end;
  int          test_id;
  logic        run_end;
  int          fail_count;
  int          checks_done;
  logic [15:0] lfsr_state;

  tcam_top #(
    .DATA_W(DATA_W), .DEPTH(DEPTH), .N_WRITE(N_WRITE), .N_READ(N_READ), .POLICY(POLICY)
  ) UUT (
    .clk(clk), .arst_n(arst_n),
    .wr_en(wr_en), .wr_mask(wr_mask), .wr_data(wr_data), .wr_addr(wr_addr),
    .srch_en(srch_en), .srch_mask(srch_mask), .srch_key(srch_key),
    .res_valid(res_valid), .res_match(res_match), .res_multi(res_multi), .res_addr(res_addr)
  );

  tcam_checker #(
    .DATA_W(DATA_W), .DEPTH(DEPTH), .N_WRITE(N_WRITE), .N_READ(N_READ), .POLICY(POLICY)
  ) u_checker (
    .clk(clk), .arst_n(arst_n),
    .wr_en(wr_en), .wr_mask(wr_mask), .wr_data(wr_data), .wr_addr(wr_addr),
    .srch_en(srch_en), .srch_mask(srch_mask), .srch_key(srch_key),
    .res_valid(res_valid), .res_match(res_match), .res_multi(res_multi), .res_addr(res_addr),
    .test_end(test_end), .test_id(test_id), .run_end(run_end),
    .fail_count(fail_count), .checks_done(checks_done)
  );

  // assertions ride on the searcher, resolved in its own scope
  bind tcam_search tcam_sva #(.N_READ(N_READ), .ADDR_W(ADDR_W)) u_sva (
    .clk(clk), .arst_n(arst_n), .req_en(srch.req_en), .rsp_valid(srch.rsp_valid),
    .rsp_match(srch.rsp_match), .rsp_multi(srch.rsp_multi), .rsp_addr(srch.rsp_addr)
  );

  // galois form, shift right and fold the taps in when a one drops out
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic clear_inputs();
    wr_en     = '0;
    wr_mask   = '0;
    wr_data   = '0;
    wr_addr   = '0;
    srch_en   = '0;
    srch_mask = '0;
    srch_key  = '0;
  endtask

  task automatic set_write(input int p, input int addr, input logic [DATA_W-1:0] data,
                           input logic [DATA_W-1:0] mask);
    wr_en[p]   = 1'b1;
    wr_addr[p] = ADDR_W'(addr);
    wr_data[p] = data;
    wr_mask[p] = mask;
  endtask

  task automatic set_search(input int r, input logic [DATA_W-1:0] key,
                            input logic [DATA_W-1:0] mask);
    srch_en[r]   = 1'b1;
    srch_key[r]  = key;
    srch_mask[r] = mask;
  endtask

  // strobes last one cycle only
  task automatic next_cycle();
    @(negedge clk);
    wr_en   = '0;
    srch_en = '0;
  endtask

  // wait until the last result strobe has gone, bounded
  task automatic drain_results();
    int waited;
    waited = 0;
    while (res_valid != '0 && waited < 8) begin
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic end_test(input int id);
    test_id  = id;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  // all ports busy, small data space so entries repeat and collide
  task automatic random_cycle();
    logic [31:0] v;
    logic [1:0]  sel;
    for (int p = 0; p < N_WRITE; p++) begin
      draw_bits(1, v);
      wr_en[p] = v[0];
      draw_bits(ADDR_W, v);
      wr_addr[p] = ADDR_W'(v);
      draw_bits(4, v);
      wr_data[p] = DATA_W'({4{v[3:0]}});
      draw_bits(1, v);
      wr_mask[p] = '0;
      if (v[0]) begin
        draw_bits(DATA_W, v);
        wr_mask[p] = DATA_W'(v);
      end
    end
    // about one cycle in four both ports hit the same entry
    draw_bits(2, v);
    if (v[1:0] == 2'b00) begin
      wr_addr[N_WRITE-1] = wr_addr[0];
    end
    for (int r = 0; r < N_READ; r++) begin
      draw_bits(2, v);
      sel = v[1:0];
      srch_en[r] = 1'b1;
      case (sel)
        // same cycle as the write, must see old content
        2'd0: begin
          srch_key[r]  = wr_data[0];
          srch_mask[r] = '0;
        end
        2'd1: begin
          draw_bits(4, v);
          srch_key[r]  = DATA_W'({4{v[3:0]}});
          srch_mask[r] = '0;
        end
        // wide don't care, many hits
        2'd2: begin
          draw_bits(DATA_W, v);
          srch_key[r] = DATA_W'(v);
          draw_bits(DATA_W, v);
          srch_mask[r] = DATA_W'(v);
          draw_bits(DATA_W, v);
          srch_mask[r] = srch_mask[r] | DATA_W'(v);
        end
        default: begin
          srch_key[r] = wr_data[N_WRITE-1];
          draw_bits(4, v);
          srch_mask[r] = DATA_W'(v[3:0]);
        end
      endcase
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("run timed out after %0d ns before the tests completed", TIMEOUT_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    lfsr_state = 16'd49;
    arst_n     = 1'b0;
    test_end   = 1'b0;
    test_id    = 0;
    run_end    = 1'b0;
    clear_inputs();
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // 1: cleared table, key zero hits every entry
    set_search(0, 16'h0000, 16'h0000);
    set_search(1, 16'h0000, 16'hffff);
    next_cycle();
    drain_results();
    end_test(1);

    // 2: distinct keys, each found at its own address
    set_write(0, 3, 16'h1234, 16'h0000);
    set_write(1, 10, 16'hbeef, 16'h0000);
    next_cycle();
    set_write(0, 25, 16'h0f0f, 16'h0000);
    set_write(1, 31, 16'ha5a5, 16'h0000);
    next_cycle();
    set_search(0, 16'h1234, 16'h0000);
    set_search(1, 16'hbeef, 16'h0000);
    next_cycle();
    set_search(0, 16'h0f0f, 16'h0000);
    set_search(1, 16'ha5a5, 16'h0000);
    next_cycle();
    // never written
    set_search(0, 16'h7777, 16'h0000);
    next_cycle();
    drain_results();
    end_test(2);

    // 3: partial writes keep the masked bits
    set_write(0, 10, 16'h1200, 16'h00ff);
    set_write(1, 3, 16'hffff, 16'hf0f0);
    next_cycle();
    set_search(0, 16'h12ef, 16'h0000);
    set_search(1, 16'h1f3f, 16'h0000);
    next_cycle();
    set_search(0, 16'h1200, 16'h0000);
    set_search(1, 16'hffff, 16'h0000);
    next_cycle();
    drain_results();
    end_test(3);

    // 4: duplicated key and widened masks, policy decides the winner
    set_write(0, 5, 16'h5555, 16'h0000);
    set_write(1, 20, 16'h5555, 16'h0000);
    next_cycle();
    set_write(0, 28, 16'h5555, 16'h0000);
    next_cycle();
    set_search(0, 16'h5555, 16'h0000);
    set_search(1, 16'h12ff, 16'h00ff);
    next_cycle();
    set_search(0, 16'h0055, 16'hff00);
    set_search(1, 16'h0000, 16'hffff);
    next_cycle();
    drain_results();
    end_test(4);

    // 5: random traffic on every port at once
    for (int c = 0; c < RAND_CYCLES; c++) begin
      random_cycle();
      next_cycle();
    end
    drain_results();
    end_test(5);

    run_end = 1'b1;
    @(negedge clk);
    run_end = 1'b0;
    if (fail_count == 0 && checks_done > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- verif/tcam_checker.sv
`timescale 1ns/1ps

module tcam_checker #(
  parameter int                    DATA_W  = 16,
  parameter int                    DEPTH   = 32,
  parameter int                    N_WRITE = 2,
  parameter int                    N_READ  = 2,
  parameter tcam_pkg::sel_policy_e POLICY  = tcam_pkg::DEF_POLICY,
  localparam int                   ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [N_WRITE-1:0]             wr_en,
  input  logic [N_WRITE-1:0][DATA_W-1:0] wr_mask,
  input  logic [N_WRITE-1:0][DATA_W-1:0] wr_data,
  input  logic [N_WRITE-1:0][ADDR_W-1:0] wr_addr,
  input  logic [N_READ-1:0]              srch_en,
  input  logic [N_READ-1:0][DATA_W-1:0]  srch_mask,
  input  logic [N_READ-1:0][DATA_W-1:0]  srch_key,
  input  logic [N_READ-1:0]              res_valid,
  input  logic [N_READ-1:0]              res_match,
  input  logic [N_READ-1:0]              res_multi,
  input  logic [N_READ-1:0][ADDR_W-1:0]  res_addr,
  input  logic                           test_end,
  input  int                             test_id,
  input  logic                           run_end,
  output int                             fail_count,
  output int                             checks_done
);

  // model of the table
  logic [DATA_W-1:0]             shadow [DEPTH];
  // expected result per port, captured when the strobe is seen
  logic [N_READ-1:0]             exp_valid;
  logic [N_READ-1:0]             exp_match;
  logic [N_READ-1:0]             exp_multi;
  logic [N_READ-1:0][ADDR_W-1:0] exp_addr;
  // counter snapshots at the start of each test
  int test_base;
  int check_base;
  int tests_passed;
  int tests_failed;

  // returns {match, multi, index} against the shadow table
  function automatic logic [ADDR_W+1:0] ref_search(input logic [DATA_W-1:0] key,
                                                   input logic [DATA_W-1:0] dont_care);
    int count;
    int winner;
    count  = 0;
    winner = 0;
    for (int e = 0; e < DEPTH; e++) begin
      if (((shadow[e] ^ key) & ~dont_care) == '0) begin
        count++;
        // low first keeps the first hit, high first keeps the last
        if (count == 1 || POLICY == tcam_pkg::HIGH_FIRST) begin
          winner = e;
        end
      end
    end
    return {count > 0, count > 1, ADDR_W'(winner)};
  endfunction

  // first port to claim an entry owns all of its bits this cycle
  // unmasked bits take the new data, masked bits stay as stored
  function automatic void apply_writes();
    logic [DEPTH-1:0] claimed;
    claimed = '0;
    for (int p = 0; p < N_WRITE; p++) begin
      if (wr_en[p] && !claimed[wr_addr[p]]) begin
        for (int b = 0; b < DATA_W; b++) begin
          if (!wr_mask[p][b]) begin
            shadow[wr_addr[p]][b] = wr_data[p][b];
          end
        end
        claimed[wr_addr[p]] = 1'b1;
      end
    end
  endfunction

  task automatic check_field(input string name, input int port, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %0t %s[%0d] expected %0h actual %0h", $time, name, port, expected, actual);
      fail_count++;
    end
  endtask

  // searches see the table as it was before this edge's writes
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int e = 0; e < DEPTH; e++) begin
        shadow[e] = '0;
      end
      exp_valid = '0;
      exp_match = '0;
      exp_multi = '0;
      exp_addr  = '0;
    end else begin
      exp_valid = srch_en;
      for (int r = 0; r < N_READ; r++) begin
        if (srch_en[r]) begin
          {exp_match[r], exp_multi[r], exp_addr[r]} = ref_search(srch_key[r], srch_mask[r]);
        end
      end
      apply_writes();
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!arst_n) begin
      fail_count  = 0;
      checks_done = 0;
    end else begin
      for (int r = 0; r < N_READ; r++) begin
        if (exp_valid[r] && !res_valid[r]) begin
          $display("%0t: search port %0d gave no result strobe after its request", $time, r);
          fail_count++;
        end else if (!exp_valid[r] && res_valid[r]) begin
          $display("%0t: search port %0d raised a result strobe without a request", $time, r);
          fail_count++;
        end else if (exp_valid[r]) begin
          checks_done++;
          check_field("res_match", r, 32'(exp_match[r]), 32'(res_match[r]));
          check_field("res_multi", r, 32'(exp_multi[r]), 32'(res_multi[r]));
          check_field("res_addr", r, 32'(exp_addr[r]), 32'(res_addr[r]));
        end
      end
    end
  end

  // per test line and the closing counts
  always @(posedge clk) begin
    if (!arst_n) begin
      test_base    = 0;
      check_base   = 0;
      tests_passed = 0;
      tests_failed = 0;
    end else begin
      if (test_end) begin
        if (fail_count == test_base) begin
          tests_passed++;
          $display("test %0d passed, %0d results checked", test_id, checks_done - check_base);
        end else begin
          tests_failed++;
          $display("test %0d failed with %0d errors", test_id, fail_count - test_base);
        end
        test_base  = fail_count;
        check_base = checks_done;
      end
      if (run_end) begin
        $display("summary: %0d tests passed, %0d tests failed, %0d results checked, %0d errors",
                 tests_passed, tests_failed, checks_done, fail_count);
      end
    end
  end

endmodule

//--- verif/tcam_sva.sv
`timescale 1ns/1ps

module tcam_sva #(
  parameter int N_READ = 2,
  parameter int ADDR_W = 5
) (
  input logic                           clk,
  input logic                           arst_n,
  input logic [N_READ-1:0]              req_en,
  input logic [N_READ-1:0]              rsp_valid,
  input logic [N_READ-1:0]              rsp_match,
  input logic [N_READ-1:0]              rsp_multi,
  input logic [N_READ-1:0][ADDR_W-1:0]  rsp_addr
);

  // result strobe is the request strobe one edge later
  a_valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid == $past(req_en))
    else $error("result strobe does not follow the search strobe by one cycle");

  // a second hit needs a first one
  a_multi_has_match: assert property (@(posedge clk) disable iff (!arst_n)
    (rsp_multi & ~rsp_match) == '0)
    else $error("multiple hit flag set without a match");

  for (genvar r = 0; r < N_READ; r++) begin : g_port
    // miss reports address zero
    a_addr_zero: assert property (@(posedge clk) disable iff (!arst_n)
      !rsp_match[r] |-> rsp_addr[r] == '0)
      else $error("nonzero result address without a match");
  end

endmodule

//--- verilog/tcam_top.sv
`timescale 1ns/1ps

module tcam_top #(
  parameter int                    DATA_W  = tcam_pkg::DEF_DATA_W,
  parameter int                    DEPTH   = tcam_pkg::DEF_DEPTH,
  parameter int                    N_WRITE = tcam_pkg::DEF_N_WRITE,
  parameter int                    N_READ  = tcam_pkg::DEF_N_READ,
  parameter tcam_pkg::sel_policy_e POLICY  = tcam_pkg::DEF_POLICY,
  localparam int                   ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                             clk,
  input  logic                             arst_n,
  // write ports
  input  logic [N_WRITE-1:0]               wr_en,
  input  logic [N_WRITE-1:0][DATA_W-1:0]   wr_mask,
  input  logic [N_WRITE-1:0][DATA_W-1:0]   wr_data,
  input  logic [N_WRITE-1:0][ADDR_W-1:0]   wr_addr,
  // search requests
  input  logic [N_READ-1:0]                srch_en,
  input  logic [N_READ-1:0][DATA_W-1:0]    srch_mask,
  input  logic [N_READ-1:0][DATA_W-1:0]    srch_key,
  // search results
  output logic [N_READ-1:0]                res_valid,
  output logic [N_READ-1:0]                res_match,
  output logic [N_READ-1:0]                res_multi,
  output logic [N_READ-1:0][ADDR_W-1:0]    res_addr
);

  // full table from store to search
  logic [DEPTH-1:0][DATA_W-1:0] entries;

  tcam_write_if #(.DATA_W(DATA_W), .DEPTH(DEPTH), .N_WRITE(N_WRITE)) wr_bus ();
  tcam_search_if #(.DATA_W(DATA_W), .DEPTH(DEPTH), .N_READ(N_READ)) srch_bus ();

  // plain ports onto the write bus
  assign wr_bus.en   = wr_en;
  assign wr_bus.mask = wr_mask;
  assign wr_bus.data = wr_data;
  assign wr_bus.addr = wr_addr;

  // plain ports onto the search bus and back
  assign srch_bus.req_en   = srch_en;
  assign srch_bus.req_mask = srch_mask;
  assign srch_bus.req_key  = srch_key;
  assign res_valid = srch_bus.rsp_valid;
  assign res_match = srch_bus.rsp_match;
  assign res_multi = srch_bus.rsp_multi;
  assign res_addr  = srch_bus.rsp_addr;

  tcam_store #(.DATA_W(DATA_W), .DEPTH(DEPTH), .N_WRITE(N_WRITE)) u_store (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr      (wr_bus.sink),
    .entries (entries)
  );

  tcam_search #(.DATA_W(DATA_W), .DEPTH(DEPTH), .N_READ(N_READ), .POLICY(POLICY)) u_search (
    .clk     (clk),
    .arst_n  (arst_n),
    .srch    (srch_bus.searcher),
    .entries (entries)
  );

endmodule

//--- tcam/tcam_search.sv
`timescale 1ns/1ps

module tcam_search #(
  parameter int                    DATA_W = 16,
  parameter int                    DEPTH  = 32,
  parameter int                    N_READ = 2,
  parameter tcam_pkg::sel_policy_e POLICY = tcam_pkg::DEF_POLICY
) (
  input  logic                         clk,
  input  logic                         arst_n,
  tcam_search_if.searcher              srch,
  input  logic [DEPTH-1:0][DATA_W-1:0] entries
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // per port hit vector over the whole table
  logic [N_READ-1:0][DEPTH-1:0]  hits;
  // combinational pick results, one lane per port
  logic [N_READ-1:0]             pick_match;
  logic [N_READ-1:0]             pick_multi;
  logic [N_READ-1:0][ADDR_W-1:0] pick_addr;

  // ternary compare
  // a bit agrees when equal or marked don't care
  always_comb begin
    for (int r = 0; r < N_READ; r++) begin
      for (int e = 0; e < DEPTH; e++) begin
        hits[r][e] = &(srch.req_mask[r] | ~(entries[e] ^ srch.req_key[r]));
      end
    end
  end

  // one priority encoder per search port
  for (genvar r = 0; r < N_READ; r++) begin : g_pick
    priority_pick #(
      .DEPTH  (DEPTH),
      .POLICY (POLICY)
    ) u_pick (
      .hits      (hits[r]),
      .any_hit   (pick_match[r]),
      .multi_hit (pick_multi[r]),
      .index     (pick_addr[r])
    );
  end

  // result register, fixed one cycle latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      srch.rsp_valid <= '0;
      srch.rsp_match <= '0;
      srch.rsp_multi <= '0;
      srch.rsp_addr  <= '0;
    end else begin
      // valid is a single cycle pulse per strobe
      srch.rsp_valid <= srch.req_en;
      for (int r = 0; r < N_READ; r++) begin
        // results only move on a strobe, otherwise hold
        if (srch.req_en[r]) begin
          srch.rsp_match[r] <= pick_match[r];
          srch.rsp_multi[r] <= pick_multi[r];
          srch.rsp_addr[r]  <= pick_addr[r];
        end
      end
    end
  end

endmodule

//--- tcam/tcam_store.sv
`timescale 1ns/1ps

module tcam_store #(
  parameter int DATA_W  = 16,
  parameter int DEPTH   = 32,
  parameter int N_WRITE = 2
) (
  input  logic                         clk,
  input  logic                         arst_n,
  tcam_write_if.sink                   wr,
  output logic [DEPTH-1:0][DATA_W-1:0] entries
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // ports addressing each entry this cycle
  logic [DEPTH-1:0][N_WRITE-1:0] port_sel;
  // table content for the next edge
  logic [DEPTH-1:0][DATA_W-1:0]  table_next;

  // address decode for every port against every entry
  always_comb begin
    for (int e = 0; e < DEPTH; e++) begin
      for (int p = 0; p < N_WRITE; p++) begin
        port_sel[e][p] = wr.en[p] && (wr.addr[p] == ADDR_W'(e));
      end
    end
  end

  // merge of all ports into each entry
  always_comb begin
    for (int e = 0; e < DEPTH; e++) begin
      // untouched entries hold
      table_next[e] = entries[e];
      // walk from the top port down
      // so the lowest selected port lands last and wins
      for (int p = N_WRITE - 1; p >= 0; p--) begin
        if (port_sel[e][p]) begin
          // masked bits come from the stored value only
          // and never from a losing port
          table_next[e] = (entries[e] & wr.mask[p])
                        | (wr.data[p] & ~wr.mask[p]);
        end
      end
    end
  end

  // entry registers
  // every entry reads zero after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      entries <= '0;
    end else begin
      entries <= table_next;
    end
  end

endmodule

//--- verilog/priority_pick.sv
`timescale 1ns/1ps

module priority_pick #(
  parameter int                    DEPTH  = 32,
  parameter tcam_pkg::sel_policy_e POLICY = tcam_pkg::DEF_POLICY
) (
  input  logic [DEPTH-1:0]                                hits,
  output logic                                            any_hit,
  output logic                                            multi_hit,
  output logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0]    index
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // at least one entry matched
  assign any_hit = |hits;

  // two or more set bits
  // a hit after an earlier hit is a second one
  always_comb begin
    logic seen;
    seen      = 1'b0;
    multi_hit = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      if (hits[i] && seen) begin
        multi_hit = 1'b1;
      end
      if (hits[i]) begin
        seen = 1'b1;
      end
    end
  end

  // first set position in scan order
  // zero when nothing hit
  always_comb begin
    logic found;
    int   pos;
    found = 1'b0;
    index = '0;
    for (int i = 0; i < DEPTH; i++) begin
      // scan direction follows the policy
      pos = (POLICY == tcam_pkg::LOW_FIRST) ? i : (DEPTH - 1 - i);
      if (!found && hits[pos]) begin
        index = ADDR_W'(pos);
        found = 1'b1;
      end
    end
  end

endmodule

//--- common/tcam_search_if.sv
`timescale 1ns/1ps

interface tcam_search_if #(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 32,
  parameter int N_READ = 2
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // request side, one lane per search port
  logic [N_READ-1:0]             req_en;
  // 1 marks a bit as don't care
  logic [N_READ-1:0][DATA_W-1:0] req_mask;
  logic [N_READ-1:0][DATA_W-1:0] req_key;

  // response side, one cycle after the strobe
  logic [N_READ-1:0]             rsp_valid;
  logic [N_READ-1:0]             rsp_match;
  // two or more entries hit
  logic [N_READ-1:0]             rsp_multi;
  logic [N_READ-1:0][ADDR_W-1:0] rsp_addr;

  modport requester (
    output req_en, output req_mask, output req_key,
    input  rsp_valid, input rsp_match, input rsp_multi, input rsp_addr
  );

  modport searcher (
    input  req_en, input req_mask, input req_key,
    output rsp_valid, output rsp_match, output rsp_multi, output rsp_addr
  );

endinterface

//--- common/tcam_write_if.sv
`timescale 1ns/1ps

interface tcam_write_if #(
  parameter int DATA_W  = 16,
  parameter int DEPTH   = 32,
  parameter int N_WRITE = 2
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // one strobe per write port
  logic [N_WRITE-1:0]             en;
  // 1 keeps the stored bit
  logic [N_WRITE-1:0][DATA_W-1:0] mask;
  // new entry value
  logic [N_WRITE-1:0][DATA_W-1:0] data;
  // target entry index
  logic [N_WRITE-1:0][ADDR_W-1:0] addr;

  // producer side, drives every port
  modport src (output en, output mask, output data, output addr);

  // table side
  modport sink (input en, input mask, input data, input addr);

endinterface

//--- common/tcam_pkg.sv
package tcam_pkg;

  // entry and key width in bits
  localparam int DEF_DATA_W = 16;

  // number of table entries
  // address width comes from this inside each module
  localparam int DEF_DEPTH = 32;

  // write ports into the table
  localparam int DEF_N_WRITE = 2;

  // independent search ports
  localparam int DEF_N_READ = 2;

  // which entry wins when several match
  typedef enum logic [0:0] {
    // lowest matching index
    LOW_FIRST  = 1'b0,
    // highest matching index
    HIGH_FIRST = 1'b1
  } sel_policy_e;

  // default winner policy
  localparam sel_policy_e DEF_POLICY = LOW_FIRST;

endpackage
